// ==== build.f ====
+incdir+.
muldiv_pkg.sv
muldiv_operand_prep.sv
muldiv_ctrl.sv
div_restoring.sv
muldiv_result_sel.sv
muldiv_unit.sv
tb_muldiv.sv

// ==== Makefile ====
# Verilator build and run of the multiply/divide unit testbench.

SOURCES = muldiv_pkg.sv muldiv_operand_prep.sv muldiv_ctrl.sv div_restoring.sv \
          muldiv_result_sel.sv muldiv_unit.sv tb_muldiv.sv tb_muldiv_table.svh

.PHONY: run clean

# Fails unless the pass line shows up in the simulator output.
run: obj_dir/Vtb_muldiv
	@out="$$(./obj_dir/Vtb_muldiv)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'all tests passed'

obj_dir/Vtb_muldiv: build.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_muldiv -f build.f

clean:
	rm -rf obj_dir

// ==== tb_muldiv_table.svh ====
// *********************************************************
// Directed rows. Columns are name, funct3, rs1, rs2,
// expected result and whether the divider runs.
// *********************************************************

`ifndef TB_MULDIV_TABLE_SVH
`define TB_MULDIV_TABLE_SVH

    task automatic load_directed_rows();
        // Multiplies, combinational.
        add_row("mul_first",    OP_MUL,    32'h0000_0007, 32'h0000_0006, 32'h0000_002A, 1'b0);
        add_row("mul_neg",      OP_MUL,    32'hFFFF_FFFD, 32'h0000_0005, 32'hFFFF_FFF1, 1'b0);
        add_row("mul_min",      OP_MUL,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 1'b0);
        add_row("mulh_neg_pos", OP_MULH,   32'hFFFF_FFFF, 32'h0000_0002, 32'hFFFF_FFFF, 1'b0);
        add_row("mulh_min_min", OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 1'b0);
        add_row("mulh_min_m1",  OP_MULH,   32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
        add_row("mulhsu_neg",   OP_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
        add_row("mulhsu_min",   OP_MULHSU, 32'h8000_0000, 32'h0000_0002, 32'hFFFF_FFFF, 1'b0);
        add_row("mulhu_max",    OP_MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 1'b0);
        add_row("mulhu_small",  OP_MULHU,  32'h8000_0000, 32'h0000_0004, 32'h0000_0002, 1'b0);
        // Divider runs and reuse.
        add_row("div_pos",      OP_DIV,    32'h0000_0064, 32'h0000_0007, 32'h0000_000E, 1'b1);
        add_row("div_neg_neg",  OP_DIV,    32'hFFFF_FF9C, 32'hFFFF_FFF7, 32'h0000_000B, 1'b1);
        add_row("rem_reuse",    OP_REM,    32'hFFFF_FF9C, 32'hFFFF_FFF7, 32'hFFFF_FFFF, 1'b0);
        add_row("divu_rerun",   OP_DIVU,   32'hFFFF_FF9C, 32'hFFFF_FFF7, 32'h0000_0000, 1'b1);
        add_row("remu_reuse",   OP_REMU,   32'hFFFF_FF9C, 32'hFFFF_FFF7, 32'hFFFF_FF9C, 1'b0);
        add_row("div_trunc",    OP_DIV,    32'h0000_0007, 32'hFFFF_FFFE, 32'hFFFF_FFFD, 1'b1);
        add_row("rem_neg",      OP_REM,    32'hFFFF_FFF9, 32'h0000_0003, 32'hFFFF_FFFF, 1'b1);
        add_row("divu_big",     OP_DIVU,   32'hFFFF_FFFF, 32'h0000_0010, 32'h0FFF_FFFF, 1'b1);
        add_row("remu_big",     OP_REMU,   32'hFFFF_FFFF, 32'h0000_000A, 32'h0000_0005, 1'b1);
        add_row("rem_pos",      OP_REM,    32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 1'b1);
        add_row("div_min_2",    OP_DIV,    32'h8000_0000, 32'h0000_0002, 32'hC000_0000, 1'b1);
        // Divide by zero, no run.
        add_row("div_zero",     OP_DIV,    32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0);
        add_row("divu_zero",    OP_DIVU,   32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0);
        add_row("rem_zero",     OP_REM,    32'hFFFF_FF9C, 32'h0000_0000, 32'hFFFF_FF9C, 1'b0);
        add_row("remu_zero",    OP_REMU,   32'h8000_0000, 32'h0000_0000, 32'h8000_0000, 1'b0);
        // Signed overflow, then the same operands unsigned.
        add_row("div_ovf",      OP_DIV,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 1'b0);
        add_row("rem_ovf",      OP_REM,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
        add_row("divu_min_m1",  OP_DIVU,   32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1);
        add_row("div_small",    OP_DIV,    32'h0000_0009, 32'h0000_0003, 32'h0000_0003, 1'b1);
        add_row("remu_min_m1",  OP_REMU,   32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 1'b1);
    endtask

`endif

// ==== tb_muldiv.sv ====
// *********************************************************
// Testbench for the multiply/divide unit. Directed table and
// LFSR rows checked against a reference model.
// *********************************************************

module tb_muldiv
    import muldiv_pkg::*;
();

    localparam int NUM_RANDOM = 24;                        // LFSR rows after the table.
    localparam int ROW_CYCLES = DIV_CYCLES + 4;            // Worst case cycles per row.
    localparam logic [DATA_WIDTH-1:0] MIN_INT = {1'b1, {(DATA_WIDTH-1){1'b0}}};

    logic                  clk;
    logic                  rstLow;
    logic [DATA_WIDTH-1:0] rs1;
    logic [DATA_WIDTH-1:0] rs2;
    muldiv_op_e            funct3;
    logic                  start;
    logic [DATA_WIDTH-1:0] result;
    logic                  busy;

    // Row storage, one entry per test.
    string                 row_name[$];
    muldiv_op_e            row_op[$];
    logic [DATA_WIDTH-1:0] row_rs1[$];
    logic [DATA_WIDTH-1:0] row_rs2[$];
    logic [DATA_WIDTH-1:0] row_exp[$];
    logic                  row_runs[$];                    // Divider run expected.
    logic                  row_rand[$];                    // Run flag comes from the model.

    logic [31:0]           lfsr_q;
    logic [DATA_WIDTH-1:0] last_a;                         // Magnitudes of the last run.
    logic [DATA_WIDTH-1:0] last_b;
    int                    pass_count;
    int                    fail_count;

    initial clk = 1'b0;
    always #4 clk = ~clk;                                  // Period of 8.

    muldiv_unit u_muldiv_unit (
        .clk      (clk),
        .rstLow   (rstLow),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .funct3_i (funct3),
        .start_i  (start),
        .result_o (result),
        .busy_o   (busy)
    );

    // *********************************************************
    // Random source and reference model
    // *********************************************************

    // Galois LFSR. Each bit taken costs one step.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits   = {bits[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hD000_0001) : (lfsr_q >> 1);
        end
        return bits;
    endfunction

    // Magnitude seen by the divider. Only DIV and REM read signed.
    function automatic logic [DATA_WIDTH-1:0] div_mag(input muldiv_op_e op,
                                                      input logic [DATA_WIDTH-1:0] v);
        if (((op == OP_DIV) || (op == OP_REM)) && v[DATA_WIDTH-1]) begin
            return -v;
        end
        return v;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] ref_result(input muldiv_op_e op,
                                                         input logic [DATA_WIDTH-1:0] a,
                                                         input logic [DATA_WIDTH-1:0] b);
        logic [2*DATA_WIDTH-1:0] a_ext;
        logic [2*DATA_WIDTH-1:0] b_ext;
        logic [2*DATA_WIDTH-1:0] prod;
        int                      sa;
        int                      sb;
        // Extend per operand, low 64 bits of the product are exact.
        a_ext = {{DATA_WIDTH{a[DATA_WIDTH-1] && (op != OP_MULHU)}}, a};
        b_ext = {{DATA_WIDTH{b[DATA_WIDTH-1] && ((op == OP_MUL) || (op == OP_MULH))}}, b};
        prod  = a_ext * b_ext;
        sa    = a;
        sb    = b;
        case (op)
            OP_MUL:    return prod[DATA_WIDTH-1:0];
            OP_MULH,
            OP_MULHSU,
            OP_MULHU:  return prod[2*DATA_WIDTH-1:DATA_WIDTH];
            OP_DIVU:   return (b == '0) ? '1 : a / b;
            OP_REMU:   return (b == '0) ? a : a % b;
            OP_DIV: begin
                if (b == '0) return '1;
                if ((a == MIN_INT) && (b == '1)) return a;
                return sa / sb;                            // Truncates toward zero.
            end
            OP_REM: begin
                if (b == '0) return a;
                if ((a == MIN_INT) && (b == '1)) return '0;
                return sa % sb;                            // Sign of the dividend.
            end
            default:   return '0;
        endcase
    endfunction

    // Divider runs unless special case or same magnitudes as last run.
    function automatic logic expect_run(input muldiv_op_e op,
                                        input logic [DATA_WIDTH-1:0] a,
                                        input logic [DATA_WIDTH-1:0] b);
        logic is_div;
        logic sgn;
        is_div = (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);
        sgn    = (op == OP_DIV) || (op == OP_REM);
        if (!is_div || (b == '0)) return 1'b0;
        if (sgn && (a == MIN_INT) && (b == '1)) return 1'b0;
        return !((div_mag(op, a) == last_a) && (div_mag(op, b) == last_b));
    endfunction

    // *********************************************************
    // Table
    // *********************************************************

    task automatic add_row(input string name, input muldiv_op_e op,
                           input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                           input logic [DATA_WIDTH-1:0] expected, input logic runs);
        row_name.push_back(name);
        row_op.push_back(op);
        row_rs1.push_back(a);
        row_rs2.push_back(b);
        row_exp.push_back(expected);
        row_runs.push_back(runs);
        row_rand.push_back(1'b0);
    endtask

`include "tb_muldiv_table.svh"

    task automatic add_random_rows();
        muldiv_op_e            op;
        logic [31:0]           code;
        logic [31:0]           shamt;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            code  = take_bits(3);
            op    = muldiv_op_e'(code[2:0]);
            a     = take_bits(DATA_WIDTH);
            shamt = take_bits(5);                          // Shorter divisors, busier quotients.
            b     = take_bits(DATA_WIDTH) >> shamt;
            add_row($sformatf("rand_%0d", i), op, a, b, ref_result(op, a, b), 1'b0);
            row_rand[row_rand.size()-1] = 1'b1;
        end
    endtask

    // *********************************************************
    // Row execution and report
    // *********************************************************

    task automatic report_test(input string name, input logic ok);
        if (ok) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s", name);
        end
    endtask

    task automatic run_row(input int idx);
        string                 name;
        logic [DATA_WIDTH-1:0] expected;
        logic                  exp_runs;
        logic                  saw_busy;
        logic                  row_ok;
        int                    wait_cycles;
        name        = row_name[idx];
        expected    = row_exp[idx];
        exp_runs    = row_rand[idx] ? expect_run(row_op[idx], row_rs1[idx], row_rs2[idx])
                                    : row_runs[idx];
        row_ok      = 1'b1;
        wait_cycles = 0;
        @(posedge clk);                                    // Idle cycle, start latch clears.
        @(posedge clk);
        #1;
        funct3 = row_op[idx];
        rs1    = row_rs1[idx];
        rs2    = row_rs2[idx];
        start  = 1'b1;
        @(negedge clk);
        saw_busy = busy;                                   // Busy rises in the start cycle.
        @(posedge clk);
        #1;
        start = 1'b0;                                      // Operands stay held.
        @(negedge clk);
        while (busy && (wait_cycles < DIV_CYCLES + 2)) begin
            saw_busy = 1'b1;
            wait_cycles++;
            @(negedge clk);
        end
        assert (!busy) else begin
            $display("%s: busy_o still high %0d cycles after start", name, wait_cycles + 1);
            row_ok = 1'b0;
        end
        assert (saw_busy == exp_runs) else begin
            if (exp_runs) begin
                $display("%s: busy_o never rose, the divider did not run", name);
            end else begin
                $display("%s: busy_o rose although no divider run was due", name);
            end
            row_ok = 1'b0;
        end
        assert (result == expected) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, result);
            row_ok = 1'b0;
        end
        if (exp_runs) begin
            last_a = div_mag(row_op[idx], row_rs1[idx]);   // Track reuse like the unit.
            last_b = div_mag(row_op[idx], row_rs2[idx]);
        end
        report_test(name, row_ok);
    endtask

    // *********************************************************
    // Main sequence
    // *********************************************************

    initial begin
        logic reset_ok;
        lfsr_q     = 32'h51db02e9;
        last_a     = '0;
        last_b     = '0;
        pass_count = 0;
        fail_count = 0;
        rstLow     = 1'b0;
        start      = 1'b0;
        rs1        = '0;
        rs2        = '0;
        funct3     = OP_MUL;
        reset_ok   = 1'b1;
        load_directed_rows();
        add_random_rows();
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            assert (!busy) else begin
                $display("reset: busy_o high during reset");
                reset_ok = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        rstLow = 1'b1;
        @(negedge clk);
        assert (!busy) else begin
            $display("reset: busy_o high after reset release");
            reset_ok = 1'b0;
        end
        report_test("reset", reset_ok);
        for (int r = 0; r < row_name.size(); r++) begin
            run_row(r);
        end
        $display("%0d passed, %0d failed, %0d tests", pass_count, fail_count,
                 pass_count + fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Limit scales with the row count, known once the table is built.
    initial begin
        longint limit;
        #1;
        limit = longint'(row_name.size() + 1) * ROW_CYCLES * 8 * 2;
        #(limit);
        $display("watchdog: run timed out after %0d time units", limit + 1);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== muldiv_unit.sv ====
// *********************************************************
// Multiply/divide unit top level. Core starts an operation
// and polls busy; multiplies finish in the same cycle.
// *********************************************************

module muldiv_unit
    import muldiv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstLow,                  // Asynchronous reset, active low.
    input  logic [DATA_WIDTH-1:0] rs1_i,                   // Multiplicand or dividend.
    input  logic [DATA_WIDTH-1:0] rs2_i,                   // Multiplier or divisor.
    input  muldiv_op_e            funct3_i,                // Operation select.
    input  logic                  start_i,                 // One cycle start pulse.
    output logic [DATA_WIDTH-1:0] result_o,                // Valid whenever busy is low.
    output logic                  busy_o                   // High while the divider runs.
);

    logic [DATA_WIDTH-1:0] a_abs;                          // Magnitude of rs1.
    logic [DATA_WIDTH-1:0] b_abs;                          // Magnitude of rs2.
    logic                  neg_q;                          // Product/quotient needs negation.
    logic                  neg_r;                          // Remainder needs negation.
    logic                  div_start;                      // Divider start pulse.
    logic                  div_zero;                       // Divisor is zero.
    logic                  div_ovf;                        // Signed overflow case.
    logic                  div_busy;                       // Divider iterating.
    logic [DATA_WIDTH-1:0] quotient;
    logic [DATA_WIDTH-1:0] remainder;

    // Signedness and magnitudes.
    muldiv_operand_prep u_operand_prep (
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .funct3_i (funct3_i),
        .a_abs_o  (a_abs),
        .b_abs_o  (b_abs),
        .neg_q_o  (neg_q),
        .neg_r_o  (neg_r)
    );

    // Special cases, start decision and busy.
    muldiv_ctrl u_ctrl (
        .clk         (clk),
        .rstLow      (rstLow),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .funct3_i    (funct3_i),
        .start_i     (start_i),
        .a_abs_i     (a_abs),
        .b_abs_i     (b_abs),
        .div_busy_i  (div_busy),
        .div_start_o (div_start),
        .div_zero_o  (div_zero),
        .div_ovf_o   (div_ovf),
        .busy_o      (busy_o)
    );

    // Unsigned iterative divider on the magnitudes.
    div_restoring u_div (
        .clk         (clk),
        .rstLow      (rstLow),
        .start_i     (div_start),
        .dividend_i  (a_abs),
        .divisor_i   (b_abs),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .busy_o      (div_busy)
    );

    // Product, sign fix-up and output mux.
    muldiv_result_sel u_result_sel (
        .funct3_i    (funct3_i),
        .a_abs_i     (a_abs),
        .b_abs_i     (b_abs),
        .rs1_i       (rs1_i),
        .neg_q_i     (neg_q),
        .neg_r_i     (neg_r),
        .quotient_i  (quotient),
        .remainder_i (remainder),
        .div_zero_i  (div_zero),
        .div_ovf_i   (div_ovf),
        .result_o    (result_o)
    );

endmodule

// ==== muldiv_result_sel.sv ====
// *********************************************************
// Result selection. Forms the product, applies the sign
// corrections and picks the output for all eight codes.
// *********************************************************

module muldiv_result_sel
    import muldiv_pkg::*;
(
    input  muldiv_op_e            funct3_i,
    input  logic [DATA_WIDTH-1:0] a_abs_i,                 // Magnitude of rs1.
    input  logic [DATA_WIDTH-1:0] b_abs_i,                 // Magnitude of rs2.
    input  logic [DATA_WIDTH-1:0] rs1_i,                   // Raw rs1 for special cases.
    input  logic                  neg_q_i,
    input  logic                  neg_r_i,
    input  logic [DATA_WIDTH-1:0] quotient_i,              // Unsigned divider quotient.
    input  logic [DATA_WIDTH-1:0] remainder_i,             // Unsigned divider remainder.
    input  logic                  div_zero_i,
    input  logic                  div_ovf_i,
    output logic [DATA_WIDTH-1:0] result_o
);

    logic [2*DATA_WIDTH-1:0] product;                      // Unsigned full product.
    logic [2*DATA_WIDTH-1:0] product_fix;                  // Product with sign applied.
    logic [DATA_WIDTH-1:0]   quotient_fix;
    logic [DATA_WIDTH-1:0]   remainder_fix;
    logic [DATA_WIDTH-1:0]   div_result;                   // DIV and DIVU outcome.
    logic [DATA_WIDTH-1:0]   rem_result;                   // REM and REMU outcome.

    // *********************************************************
    // Multiply
    // *********************************************************

    assign product     = a_abs_i * b_abs_i;
    assign product_fix = neg_q_i ? -product : product;     // MULHU never sets neg_q.

    // *********************************************************
    // Divide
    // *********************************************************

    // Sign flags stay low for the unsigned codes.
    assign quotient_fix  = neg_q_i ? -quotient_i : quotient_i;
    assign remainder_fix = neg_r_i ? -remainder_i : remainder_i;

    // Zero divisor wins over overflow, which only the signed codes raise.
    always_comb begin
        if (div_zero_i) begin
            div_result = '1;                               // All ones quotient.
            rem_result = rs1_i;                            // Dividend as remainder.
        end else if (div_ovf_i) begin
            div_result = rs1_i;                            // Most negative value.
            rem_result = '0;
        end else begin
            div_result = quotient_fix;
            rem_result = remainder_fix;
        end
    end

    // *********************************************************
    // Output select
    // *********************************************************

    always_comb begin
        result_o = div_result;
        case (funct3_i)
            OP_MUL:    result_o = product_fix[DATA_WIDTH-1:0];
            OP_MULH,
            OP_MULHSU,
            OP_MULHU:  result_o = product_fix[2*DATA_WIDTH-1:DATA_WIDTH];
            OP_DIV,
            OP_DIVU:   result_o = div_result;
            OP_REM,
            OP_REMU:   result_o = rem_result;
            default:   result_o = div_result;
        endcase
    end

endmodule

// ==== div_restoring.sv ====
// *********************************************************
// Unsigned restoring divider, one quotient bit per cycle.
// Holds its last quotient and remainder until a new start.
// *********************************************************

module div_restoring
    import muldiv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstLow,
    input  logic                  start_i,                 // Load operands and begin.
    input  logic [DATA_WIDTH-1:0] dividend_i,
    input  logic [DATA_WIDTH-1:0] divisor_i,
    output logic [DATA_WIDTH-1:0] quotient_o,
    output logic [DATA_WIDTH-1:0] remainder_o,
    output logic                  busy_o                   // High for DIV_CYCLES cycles.
);

    logic [DATA_WIDTH-1:0]    rem_q;                       // Partial remainder.
    logic [DATA_WIDTH-1:0]    quo_q;                       // Dividend bits out, quotient bits in.
    logic [DATA_WIDTH-1:0]    divisor_q;                   // Divisor held for the run.
    logic [DIV_CNT_WIDTH-1:0] count_q;                     // Iterations left.
    logic [DATA_WIDTH:0]      shifted;                     // Remainder with next dividend bit.
    logic [DATA_WIDTH:0]      diff;                        // Trial subtraction.
    logic                     fits;                        // Divisor fits, quotient bit is 1.

    // *********************************************************
    // Trial subtraction
    // *********************************************************

    assign shifted = {rem_q, quo_q[DATA_WIDTH-1]};
    assign diff    = shifted - {1'b0, divisor_q};
    assign fits    = !diff[DATA_WIDTH];                    // No borrow out.

    // *********************************************************
    // Iteration registers
    // *********************************************************

    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            rem_q   <= '0;
            quo_q   <= '0;
            count_q <= '0;
        end else if (start_i) begin
            rem_q   <= '0;
            quo_q   <= dividend_i;                         // Dividend shifts out from the top.
            count_q <= DIV_CNT_WIDTH'(DIV_CYCLES);
        end else if (busy_o) begin
            // Keep the difference, or restore by keeping the shifted value.
            rem_q   <= fits ? diff[DATA_WIDTH-1:0] : shifted[DATA_WIDTH-1:0];
            quo_q   <= {quo_q[DATA_WIDTH-2:0], fits};
            count_q <= count_q - 1'b1;
        end
    end

    // Divisor for the run, loaded with each start.
    always_ff @(posedge clk) begin
        if (start_i) begin
            divisor_q <= divisor_i;
        end
    end

    assign busy_o      = (count_q != '0);                  // Drops after the last iteration.
    assign quotient_o  = quo_q;
    assign remainder_o = rem_q;

endmodule

// ==== muldiv_ctrl.sv ====
// *********************************************************
// Control for the multiply/divide unit. Flags special divide
// cases, issues divider starts and forms the busy flag.
// *********************************************************

module muldiv_ctrl
    import muldiv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstLow,
    input  logic [DATA_WIDTH-1:0] rs1_i,                   // Raw dividend.
    input  logic [DATA_WIDTH-1:0] rs2_i,                   // Raw divisor.
    input  muldiv_op_e            funct3_i,
    input  logic                  start_i,                 // Start request from the core.
    input  logic [DATA_WIDTH-1:0] a_abs_i,                 // Dividend magnitude.
    input  logic [DATA_WIDTH-1:0] b_abs_i,                 // Divisor magnitude.
    input  logic                  div_busy_i,              // Divider still iterating.
    output logic                  div_start_o,             // Single cycle divider start.
    output logic                  div_zero_o,              // Divide by zero.
    output logic                  div_ovf_o,               // Most negative / -1.
    output logic                  busy_o
);

    logic                  is_div;                         // Divide or remainder code.
    logic                  is_signed_div;                  // DIV or REM.
    logic                  reuse;                          // Same magnitudes as last run.
    logic                  start_lat_q;                    // Set from start until divider idle.
    logic [DATA_WIDTH-1:0] a_prev_q;                       // Magnitudes of the last run.
    logic [DATA_WIDTH-1:0] b_prev_q;

    // *********************************************************
    // Special cases
    // *********************************************************

    assign is_div        = funct3_i[2];
    assign is_signed_div = (funct3_i == OP_DIV) || (funct3_i == OP_REM);

    assign div_zero_o = (rs2_i == '0);

    // Quotient 2^(W-1) does not fit in a signed word.
    assign div_ovf_o = is_signed_div
                     && (rs1_i == {1'b1, {(DATA_WIDTH-1){1'b0}}})
                     && (rs2_i == '1);

    // *********************************************************
    // Operand reuse
    // *********************************************************

    // The divider only sees magnitudes, so signed and unsigned forms
    // share a run as long as the magnitudes agree.
    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            a_prev_q <= '0;
            b_prev_q <= '0;
        end else if (div_start_o) begin
            a_prev_q <= a_abs_i;                           // Capture at the start edge.
            b_prev_q <= b_abs_i;
        end
    end

    assign reuse = (a_prev_q == a_abs_i) && (b_prev_q == b_abs_i);

    // *********************************************************
    // Start pulse and busy
    // *********************************************************

    // Latch holds off a held start_i until the divider has finished.
    always_ff @(posedge clk or negedge rstLow) begin
        if (!rstLow) begin
            start_lat_q <= 1'b0;
        end else if (start_lat_q) begin
            start_lat_q <= div_busy_i;                     // Clear once the run ends.
        end else begin
            start_lat_q <= div_start_o;
        end
    end

    assign div_start_o = start_i
                       && is_div
                       && !div_zero_o
                       && !div_ovf_o
                       && !reuse
                       && !start_lat_q
                       && !div_busy_i;

    // High in the start cycle already, so the core stalls at once.
    assign busy_o = div_start_o || div_busy_i;

endmodule

// ==== muldiv_operand_prep.sv ====
// *********************************************************
// Operand preparation. Turns signed operands into magnitudes
// and works out the result sign corrections.
// *********************************************************

module muldiv_operand_prep
    import muldiv_pkg::*;
(
    input  logic [DATA_WIDTH-1:0] rs1_i,
    input  logic [DATA_WIDTH-1:0] rs2_i,
    input  muldiv_op_e            funct3_i,
    output logic [DATA_WIDTH-1:0] a_abs_o,                 // Magnitude of rs1.
    output logic [DATA_WIDTH-1:0] b_abs_o,                 // Magnitude of rs2.
    output logic                  neg_q_o,                 // Negate product or quotient.
    output logic                  neg_r_o                  // Negate remainder.
);

    logic rs1_signed;                                      // rs1 read as two's complement.
    logic rs2_signed;                                      // rs2 read as two's complement.
    logic a_neg;                                           // rs1 counts and is negative.
    logic b_neg;                                           // rs2 counts and is negative.

    // M extension rule. MULHSU takes rs1 signed, rs2 unsigned.
    assign rs2_signed = (funct3_i == OP_MUL)
                     || (funct3_i == OP_MULH)
                     || (funct3_i == OP_DIV)
                     || (funct3_i == OP_REM);
    assign rs1_signed = rs2_signed || (funct3_i == OP_MULHSU);

    assign a_neg = rs1_signed && rs1_i[DATA_WIDTH-1];
    assign b_neg = rs2_signed && rs2_i[DATA_WIDTH-1];

    // Most negative value maps onto itself, which is the right magnitude
    // when read unsigned.
    assign a_abs_o = a_neg ? -rs1_i : rs1_i;
    assign b_abs_o = b_neg ? -rs2_i : rs2_i;

    assign neg_q_o = a_neg ^ b_neg;                        // Signs differ.
    assign neg_r_o = a_neg;                                // Remainder follows the dividend.

endmodule

// ==== muldiv_pkg.sv ====
// *********************************************************
// Shared widths and funct3 operation codes for the RV32 M
// extension multiply/divide unit.
// *********************************************************

package muldiv_pkg;

    // *********************************************************
    // Datapath sizes
    // *********************************************************

    localparam int DATA_WIDTH = 32;                        // Operand and result width.

    // The divider retires one quotient bit per cycle.
    localparam int DIV_CYCLES = DATA_WIDTH;                // Divider iterations per run.

    // Counter wide enough to hold DIV_CYCLES itself.
    localparam int DIV_CNT_WIDTH = $clog2(DIV_CYCLES + 1);

    // *********************************************************
    // Operation codes
    // *********************************************************

    // funct3 of the OP opcode with funct7 = 0000001.
    // Bit 2 separates multiplies from divides.
    // Bit 0 marks the unsigned divide forms.
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,                                // Signed x signed, low half.
        OP_MULH   = 3'b001,                                // Signed x signed, high half.
        OP_MULHSU = 3'b010,                                // Signed rs1 x unsigned rs2, high half.
        OP_MULHU  = 3'b011,                                // Unsigned x unsigned, high half.
        OP_DIV    = 3'b100,                                // Signed quotient.
        OP_DIVU   = 3'b101,                                // Unsigned quotient.
        OP_REM    = 3'b110,                                // Signed remainder.
        OP_REMU   = 3'b111                                 // Unsigned remainder.
    } muldiv_op_e;

endpackage
